// File: vlog.f
+incdir+design
design/scope_pkg.sv
design/cmd_rx.sv
design/acq_trigger.sv
design/sample_ram.sv
design/cmd_exec.sv
design/scope_top.sv
verification/scope_tb.sv

// File: run.sh
#!/bin/bash
# build the scope testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module scope_tb -o scope_sim \
	&& ./obj_dir/scope_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx "Test completed successfully" sim.log && { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }

// File: verification/scope_tb.sv
/* scope testbench
   directed tests over the host command path and the acquisition channel,
   with a software model of the ring buffer and the write pointer */

`include "scope_defines.svh"

module scope_tb;

	localparam int MAX_WAIT  = 300;   // cycles per wait loop
	localparam int LEVEL     = 128;   // trigger level byte
	localparam int HYST      = 16;    // hysteresis byte
	localparam int PREOFFSET = 4;
	localparam int TOT       = 2;

	logic               clk;
	logic               rstn;
	logic               i_rx_valid;
	scope_pkg::byte_t   i_rx_data;
	logic               o_rx_ready;
	logic               o_tx_valid;
	logic [31:0]        o_tx_data;
	logic [3:0]         o_tx_keep;
	logic               o_tx_last;
	logic               i_tx_ready;
	scope_pkg::sample_t i_sample;
	logic               i_sample_valid;

	scope_pkg::sample_t   model_mem [1 << `RAM_AW];  // expected buffer contents
	scope_pkg::ram_addr_t model_wp;                  // expected write pointer
	int                   model_events;
	scope_pkg::sample_t   stim [$];
	logic [31:0]          got_data [$];
	logic [3:0]           got_keep [$];
	scope_pkg::sample_t   thr_lo;
	scope_pkg::sample_t   thr_hi;
	integer               seed = 32'hf506;
	int                   checks;
	int                   errors;
	int                   test_errs;
	event                 timed_out;

	scope_top scope_top_inst (
		.clk(clk), .rstn(rstn),
		.i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .o_rx_ready(o_rx_ready),
		.o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_keep(o_tx_keep),
		.o_tx_last(o_tx_last), .i_tx_ready(i_tx_ready),
		.i_sample(i_sample), .i_sample_valid(i_sample_valid)
	);

	always #20 clk = ~clk;  // period 40

	// --------------------------------------------------
	// compare tasks
	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_keep(input string name, input logic [3:0] got, input logic [3:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_sample(input string name, input scope_pkg::sample_t got,
			input scope_pkg::sample_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input scope_pkg::count16_t got,
			input scope_pkg::count16_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic complain(input string what);
		checks++;
		errors++;
		$display("at %0t %s", $time, what);
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout at %0t, %s", $time, what);
		-> timed_out;
	endtask

	// a wait loop that ran out ends the run here
	initial begin
		@(timed_out);
		$display("Test failed");
		$finish;
	end

	// level byte to 12-bit threshold
	function automatic scope_pkg::sample_t level_to_thresh(input int level);
		level_to_thresh = scope_pkg::sample_t'(((level - `THRESH_MID) << `THRESH_SHIFT)
			+ `THRESH_ROUND);
	endfunction

	// opcode and arg1..arg5 with arg6/7 zero
	function automatic scope_pkg::cmd_frame_t make_frame(input int op, input int a1,
			input int a2, input int a3, input int a4, input int a5);
		make_frame = scope_pkg::cmd_frame_t'({op[7:0], a1[7:0], a2[7:0], a3[7:0],
			a4[7:0], a5[7:0], 16'h0000});
	endfunction

	// --------------------------------------------------
	// drivers
	task automatic send_cmd(input scope_pkg::cmd_frame_t frame);
		logic [63:0] bits;
		int          i;
		int          wait_cnt;
		bits = frame;
		@(posedge clk);
		for (i = 0; i < `CMD_BYTES; i++) begin
			i_rx_valid <= 1'b1;
			i_rx_data  <= bits[63 - 8 * i -: 8];  // opcode first
			wait_cnt = 0;
			do begin
				@(negedge clk);
				wait_cnt++;
				if (wait_cnt > MAX_WAIT) stop_on_timeout("command byte never accepted");
			end while (!o_rx_ready);
			@(posedge clk);  // byte taken here
		end
		i_rx_valid <= 1'b0;
		@(negedge clk);
		check_flag("o_rx_ready", o_rx_ready, 1'b0);  // held off while the frame is out
	endtask

	// gathers words up to the one with last set
	task automatic collect_words(input bit backpressure);
		int          loop_cnt;
		bit          done;
		bit          held;
		logic [36:0] held_word;
		got_data.delete();
		got_keep.delete();
		loop_cnt = 0;
		done     = 1'b0;
		held     = 1'b0;
		while (!done) begin
			@(posedge clk);
			i_tx_ready <= backpressure ? (($random(seed) & 1) != 0) : 1'b1;
			@(negedge clk);
			if (held && !(o_tx_valid && {o_tx_data, o_tx_keep, o_tx_last} == held_word))
				complain("output word changed while ready was low");
			held = 1'b0;
			if (o_tx_valid && i_tx_ready) begin  // transfers on next edge
				got_data.push_back(o_tx_data);
				got_keep.push_back(o_tx_keep);
				done = o_tx_last;
			end else if (o_tx_valid) begin
				held      = 1'b1;
				held_word = {o_tx_data, o_tx_keep, o_tx_last};
			end
			loop_cnt++;
			if (loop_cnt > MAX_WAIT) stop_on_timeout("response never ended with last");
		end
		@(posedge clk);
		i_tx_ready <= 1'b1;
	endtask

	// only the first n_keep samples of stim land in the buffer
	task automatic drive_samples(input int n_keep);
		int i;
		for (i = 0; i < stim.size(); i++) begin
			@(posedge clk);
			i_sample_valid <= 1'b1;
			i_sample       <= stim[i];
			if (i < n_keep) begin
				model_mem[model_wp] = stim[i];
				model_wp = scope_pkg::ram_addr_t'(model_wp + 1);
			end
		end
		@(posedge clk);
		i_sample_valid <= 1'b0;
	endtask

	// --------------------------------------------------
	// response checks
	task automatic expect_count_of_words(input int n, output bit ok);
		ok = (got_data.size() == n);
		if (!ok) complain($sformatf("expected %0d response words, got %0d", n, got_data.size()));
	endtask

	task automatic expect_word(input logic [31:0] exp);
		bit ok;
		collect_words(1'b0);
		expect_count_of_words(1, ok);
		if (ok) begin
			check_word("o_tx_data", got_data[0], exp);
			check_keep("o_tx_keep", got_keep[0], 4'b1111);
		end
	endtask

	task automatic expect_status(input scope_pkg::count16_t evt, input scope_pkg::count16_t post);
		bit ok;
		collect_words(1'b0);
		expect_count_of_words(1, ok);
		if (ok) begin
			check_count("event_count", got_data[0][31:16], evt);
			check_count("post_count", got_data[0][15:0], post);
			check_keep("o_tx_keep", got_keep[0], 4'b1111);
		end
	endtask

	task automatic check_readout(input scope_pkg::ram_addr_t trig, input int len, input bit bp);
		bit                   ok;
		int                   k;
		int                   n;
		scope_pkg::ram_addr_t a;
		logic [3:0]           keep_exp;
		send_cmd(make_frame(0, 0, 0, 0, len & 255, len >> 8));
		collect_words(bp);
		n = (len + 3) / 4;
		expect_count_of_words(n, ok);
		for (k = 0; ok && k < n; k++) begin
			a = scope_pkg::ram_addr_t'(int'(trig) - PREOFFSET + 2 * k);  // wraps at 1024
			check_sample("o_tx_data[11:0]", got_data[k][11:0], model_mem[a]);
			check_sample("o_tx_data[27:16]", got_data[k][27:16],
				model_mem[scope_pkg::ram_addr_t'(a + 1)]);
			check_word("o_tx_data pad bits", got_data[k] & 32'hf000_f000, 32'h0);
			keep_exp = 4'b1111;
			if (k == n - 1 && (len % 4) != 0) keep_exp = 4'((1 << (len % 4)) - 1);
			check_keep("o_tx_keep", got_keep[k], keep_exp);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %-10s %s (%0d errors)", name,
			(errors == test_errs) ? "ok" : "FAILED", errors - test_errs);
		test_errs = errors;
	endtask

	// --------------------------------------------------
	// tests
	task automatic fill_buffer();
		int a;
		stim.delete();
		for (a = 0; a < (1 << `RAM_AW); a++)
			stim.push_back(scope_pkg::sample_t'({a[9:0], 2'b01} ^ {2'b00, ~a[9:0]}));
		drive_samples(1 << `RAM_AW);  // every sample written while idle
	endtask

	task automatic test_immediate();
		scope_pkg::ram_addr_t trig;
		int                   i;
		send_cmd(make_frame(8, LEVEL, HYST, PREOFFSET >> 8, PREOFFSET & 255, TOT));
		expect_word(32'd8);
		send_cmd(make_frame(1, 0, 0, 0, 10, 0));  // TRIG_NONE with length 10
		expect_status(16'(model_events), 16'h0000);
		stim.delete();
		for (i = 0; i < 20; i++) stim.push_back(scope_pkg::sample_t'(100 + 7 * i));
		trig = model_wp;  // first sample after arm
		drive_samples(11);
		model_events++;
		send_cmd(make_frame(1, 0, 0, 0, 10, 0));
		expect_status(16'(model_events), 16'hffff);
		check_readout(trig, 32, 1'b0);
		end_test("immediate");
	endtask

	task automatic test_falling();
		scope_pkg::ram_addr_t trig;
		int                   i;
		send_cmd(make_frame(1, 1, 0, 0, 8, 0));  // TRIG_FALL with length 8
		expect_status(16'(model_events), 16'h0000);
		stim.delete();
		for (i = 0; i < 24; i++) begin
			if (i < 5) stim.push_back(scope_pkg::sample_t'(3 * i));  // mid level
			else if (i < 8) stim.push_back(scope_pkg::sample_t'(thr_lo - 20 - i));
			else if (i < 10) stim.push_back(scope_pkg::sample_t'(i));
			else stim.push_back(scope_pkg::sample_t'(thr_hi + 10 + i));
		end
		trig = scope_pkg::ram_addr_t'(model_wp + 12);  // third above upper
		drive_samples(12 + 8 + 1);
		model_events++;
		send_cmd(make_frame(1, 1, 0, 0, 8, 0));
		expect_status(16'(model_events), 16'hffff);
		check_readout(trig, 32, 1'b0);
		end_test("falling");
	endtask

	task automatic test_rising();
		scope_pkg::ram_addr_t trig;
		int                   i;
		send_cmd(make_frame(1, 2, 0, 0, 6, 0));  // TRIG_RISE with length 6
		expect_status(16'(model_events), 16'h0000);
		stim.delete();
		for (i = 0; i < 21; i++) begin
			if (i < 4) stim.push_back(scope_pkg::sample_t'(-i));
			else if (i < 7) stim.push_back(scope_pkg::sample_t'(thr_hi + 30 + i));
			else if (i < 9) stim.push_back(scope_pkg::sample_t'(i));
			else stim.push_back(scope_pkg::sample_t'(thr_lo - 30 - i));
		end
		trig = scope_pkg::ram_addr_t'(model_wp + 11);  // third below lower
		drive_samples(11 + 6 + 1);
		model_events++;
		check_readout(trig, 10, 1'b1);  // random ready
		end_test("rising");
	endtask

	task automatic test_unknown();
		int i;
		bit seen;
		send_cmd(make_frame(5, 0, 0, 0, 0, 0));
		seen = 1'b0;
		for (i = 0; i < 40; i++) begin
			@(negedge clk);
			if (o_tx_valid) seen = 1'b1;
		end
		if (seen) complain("DUT answered an unknown opcode");
		else checks++;
		send_cmd(make_frame(2, 0, 0, 0, 0, 0));
		expect_word(32'(`SCOPE_VERSION));
		end_test("unknown");
	endtask

	task automatic test_rearm();
		scope_pkg::ram_addr_t trig;
		int                   i;
		send_cmd(make_frame(1, 0, 0, 0, 4, 0));
		expect_status(16'(model_events), 16'h0000);
		stim.delete();
		for (i = 0; i < 10; i++) stim.push_back(scope_pkg::sample_t'(50 + i));
		trig = model_wp;
		drive_samples(5);
		model_events++;
		send_cmd(make_frame(1, 0, 0, 0, 4, 0));  // ignored while the event is held
		expect_status(16'(model_events), 16'hffff);
		stim.delete();
		for (i = 0; i < 6; i++) stim.push_back(scope_pkg::sample_t'(-900 - i));
		drive_samples(0);  // buffer frozen while the event is held
		check_readout(trig, 24, 1'b0);
		send_cmd(make_frame(1, 0, 0, 0, 4, 0));
		expect_status(16'(model_events), 16'h0000);
		stim.delete();
		for (i = 0; i < 10; i++) stim.push_back(scope_pkg::sample_t'(-60 - 3 * i));
		trig = model_wp;
		drive_samples(5);
		model_events++;
		send_cmd(make_frame(1, 0, 0, 0, 4, 0));
		expect_status(16'(model_events), 16'hffff);
		check_readout(trig, 16, 1'b0);
		end_test("rearm");
	endtask

	initial begin
		clk            = 1'b0;
		rstn           = 1'b0;
		i_rx_valid     = 1'b0;
		i_rx_data      = '0;
		i_tx_ready     = 1'b1;
		i_sample       = '0;
		i_sample_valid = 1'b0;
		model_wp       = '0;
		model_events   = 0;
		checks         = 0;
		errors         = 0;
		test_errs      = 0;
		thr_lo         = level_to_thresh(LEVEL - HYST);
		thr_hi         = level_to_thresh(LEVEL + HYST);
		repeat (3) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		fill_buffer();
		send_cmd(make_frame(2, 0, 0, 0, 0, 0));
		expect_word(32'(`SCOPE_VERSION));
		end_test("version");
		test_immediate();
		test_falling();
		test_rising();
		test_unknown();
		test_rearm();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: design/scope_top.sv
/* digitizer top
   command receiver and acquisition side by side, executor on top,
   sample buffer between acquisition and readout */

module scope_top (
	input  logic               clk,
	input  logic               rstn,
	// host bytes in
	input  logic               i_rx_valid,
	input  scope_pkg::byte_t   i_rx_data,
	output logic               o_rx_ready,
	// host words out
	output logic               o_tx_valid,
	output logic [31:0]        o_tx_data,
	output logic [3:0]         o_tx_keep,
	output logic               o_tx_last,
	input  logic               i_tx_ready,
	// adc
	input  scope_pkg::sample_t i_sample,
	input  logic               i_sample_valid
);

	scope_pkg::cmd_frame_t  frame;
	logic                   frame_valid;
	logic                   listen;
	scope_pkg::acq_cfg_t    cfg;
	logic                   arm;
	logic                   readout_done;
	scope_pkg::acq_status_t status;
	logic                   wr_en;
	scope_pkg::ram_addr_t   wr_addr;
	scope_pkg::sample_t     wr_data;
	scope_pkg::ram_addr_t   rd_addr;
	scope_pkg::sample_t     rd_data;

	cmd_rx cmd_rx_inst (
		.clk(clk), .rstn(rstn),
		.i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .o_rx_ready(o_rx_ready),
		.i_listen(listen), .o_frame(frame), .o_frame_valid(frame_valid)
	);

	acq_trigger acq_trigger_inst (
		.clk(clk), .rstn(rstn),
		.i_sample(i_sample), .i_sample_valid(i_sample_valid),
		.i_cfg(cfg), .i_arm(arm), .i_readout_done(readout_done), .o_status(status),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data)
	);

	sample_ram sample_ram_inst (
		.clk(clk), .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_rd_addr(rd_addr), .o_rd_data(rd_data)
	);

	cmd_exec cmd_exec_inst (
		.clk(clk), .rstn(rstn),
		.i_frame(frame), .i_frame_valid(frame_valid), .o_listen(listen),
		.i_status(status), .o_cfg(cfg), .o_arm(arm), .o_readout_done(readout_done),
		.o_rd_addr(rd_addr), .i_rd_data(rd_data),
		.o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_keep(o_tx_keep),
		.o_tx_last(o_tx_last), .i_tx_ready(i_tx_ready)
	);

endmodule

// File: design/cmd_exec.sv
/* command executor
   decodes host frames, keeps trigger settings, answers with one word
   or streams the held event as packed sample pairs */

`include "scope_defines.svh"

module cmd_exec (
	input  logic                   clk,
	input  logic                   rstn,
	input  scope_pkg::cmd_frame_t  i_frame,
	input  logic                   i_frame_valid,
	output logic                   o_listen,
	input  scope_pkg::acq_status_t i_status,
	output scope_pkg::acq_cfg_t    o_cfg,
	output logic                   o_arm,
	output logic                   o_readout_done,
	output scope_pkg::ram_addr_t   o_rd_addr,
	input  scope_pkg::sample_t     i_rd_data,
	output logic                   o_tx_valid,
	output logic [31:0]            o_tx_data,
	output logic [3:0]             o_tx_keep,
	output logic                   o_tx_last,
	input  logic                   i_tx_ready
);

	scope_pkg::exec_state_e state;
	scope_pkg::opcode_e     opcode;
	scope_pkg::ram_addr_t   preoffset;   // samples shown before the trigger
	scope_pkg::sample_t     lo_q;        // even sample of the pair
	scope_pkg::sample_t     thr_lo;
	scope_pkg::sample_t     thr_hi;
	logic [31:0]            rd_len;      // requested byte count
	logic [31:0]            len_q;       // bytes still to go
	logic [31:0]            resp_word;
	logic                   resp_en;
	logic                   last_word;
	logic [3:0]             last_keep;

	assign o_listen = (state == scope_pkg::EX_RX);
	assign opcode   = scope_pkg::opcode_e'(i_frame.opcode);
	assign rd_len   = {i_frame.arg7, i_frame.arg6, i_frame.arg5, i_frame.arg4};  // little endian

	// ---------------------------------------------------
	// level byte +/- hysteresis to 12-bit thresholds
	assign thr_lo = ((`SAMPLE_W'(i_frame.arg1) - `SAMPLE_W'(i_frame.arg2)
		- `SAMPLE_W'(`THRESH_MID)) << `THRESH_SHIFT) + `SAMPLE_W'(`THRESH_ROUND);
	assign thr_hi = ((`SAMPLE_W'(i_frame.arg1) + `SAMPLE_W'(i_frame.arg2)
		- `SAMPLE_W'(`THRESH_MID)) << `THRESH_SHIFT) + `SAMPLE_W'(`THRESH_ROUND);

	// tail word keep
	assign last_word = (len_q <= 32'd4);
	always_comb begin
		case (len_q[2:0])
			3'd1:    last_keep = 4'b0001;
			3'd2:    last_keep = 4'b0011;
			3'd3:    last_keep = 4'b0111;
			default: last_keep = 4'b1111;
		endcase
	end

	// single word answers, readout and unknown ops have none
	always_comb begin
		resp_word = '0;
		resp_en   = 1'b1;
		case (opcode)
			scope_pkg::OP_ARM:      resp_word = {i_status.event_count, i_status.post_count};
			scope_pkg::OP_INFO: begin
				resp_word = 32'(`SCOPE_VERSION);
				resp_en   = (i_frame.arg1 == 8'd0);  // other info pages dropped
			end
			scope_pkg::OP_TRIG_SET: resp_word = 32'(scope_pkg::OP_TRIG_SET);
			default:                resp_en   = 1'b0;
		endcase
	end

	// pair low half
	always_ff @(posedge clk) begin
		if (state == scope_pkg::EX_RD_LO) lo_q <= i_rd_data;
	end

	// ---------------------------------------------------
	// main FSM
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= scope_pkg::EX_RX;
			o_cfg          <= '0;
			preoffset      <= '0;
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
			o_rd_addr      <= '0;
			len_q          <= '0;
			o_tx_valid     <= 1'b0;
			o_tx_data      <= '0;
			o_tx_keep      <= '0;
			o_tx_last      <= 1'b0;
		end else begin
			o_arm          <= 1'b0;  // pulses
			o_readout_done <= 1'b0;
			case (state)
				scope_pkg::EX_RX: begin
					if (i_frame_valid) begin
						o_rd_addr <= i_status.trig_addr - preoffset;  // mod 1024
						state     <= scope_pkg::EX_PROCESS;
					end
				end

				scope_pkg::EX_PROCESS: begin
					if (opcode == scope_pkg::OP_READOUT) begin
						len_q     <= rd_len;
						o_rd_addr <= o_rd_addr + 1'b1;  // start fetched this cycle
						state     <= (rd_len == 32'd0) ? scope_pkg::EX_RX : scope_pkg::EX_RD_LO;
					end else if (resp_en) begin
						o_tx_data  <= resp_word;
						o_tx_keep  <= 4'b1111;
						o_tx_last  <= 1'b1;
						o_tx_valid <= 1'b1;
						state      <= scope_pkg::EX_TX_CONST;
					end else begin
						state <= scope_pkg::EX_RX;
					end
					if (opcode == scope_pkg::OP_ARM) begin
						o_cfg.trig_type      <= scope_pkg::trig_type_e'(i_frame.arg1);
						o_cfg.length_to_take <= {i_frame.arg5, i_frame.arg4};
						o_arm                <= 1'b1;
					end
					if (opcode == scope_pkg::OP_TRIG_SET) begin
						o_cfg.lower <= thr_lo;
						o_cfg.upper <= thr_hi;
						o_cfg.tot   <= i_frame.arg5;
						preoffset   <= {i_frame.arg3[1:0], i_frame.arg4};
					end
				end

				scope_pkg::EX_TX_CONST: begin
					if (i_tx_ready) begin
						o_tx_valid <= 1'b0;
						o_tx_last  <= 1'b0;
						state      <= scope_pkg::EX_RX;
					end
				end

				scope_pkg::EX_RD_LO: begin
					o_rd_addr <= o_rd_addr + 1'b1;  // odd sample next
					state     <= scope_pkg::EX_RD_HI;
				end

				scope_pkg::EX_RD_HI: begin
					o_tx_data  <= {4'b0000, i_rd_data, 4'b0000, lo_q};
					o_tx_keep  <= last_word ? last_keep : 4'b1111;
					o_tx_last  <= last_word;
					o_tx_valid <= 1'b1;
					state      <= scope_pkg::EX_TX_DATA;
				end

				scope_pkg::EX_TX_DATA: begin
					if (i_tx_ready) begin
						o_tx_valid <= 1'b0;
						o_tx_last  <= 1'b0;
						if (o_tx_last) begin
							o_readout_done <= 1'b1;  // release the event
							state          <= scope_pkg::EX_RX;
						end else begin
							len_q     <= len_q - 32'd4;
							o_rd_addr <= o_rd_addr + 1'b1;
							state     <= scope_pkg::EX_RD_LO;
						end
					end
				end

				default: state <= scope_pkg::EX_RX;
			endcase
		end
	end

	a_tx_hold: assert property (@(posedge clk) disable iff (!rstn)
		(o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_data)
			&& $stable(o_tx_keep) && $stable(o_tx_last)));

endmodule

// File: design/sample_ram.sv
/* sample ring buffer
   1024 x 12 bits, one write port and one registered read port */

`include "scope_defines.svh"

module sample_ram (
	input  logic                 clk,
	input  logic                 i_wr_en,
	input  scope_pkg::ram_addr_t i_wr_addr,
	input  scope_pkg::sample_t   i_wr_data,
	input  scope_pkg::ram_addr_t i_rd_addr,
	output scope_pkg::sample_t   o_rd_data
);

	localparam int DEPTH = 1 << `RAM_AW;

	scope_pkg::sample_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// one cycle read, old data on a same-address write
	always_ff @(posedge clk) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

// File: design/acq_trigger.sv
/* acquisition and trigger
   writes every valid sample into the ring buffer, finds the trigger,
   takes the post-trigger samples and holds the event until readout */

module acq_trigger (
	input  logic                   clk,
	input  logic                   rstn,
	input  scope_pkg::sample_t     i_sample,
	input  logic                   i_sample_valid,
	input  scope_pkg::acq_cfg_t    i_cfg,
	input  logic                   i_arm,
	input  logic                   i_readout_done,
	output scope_pkg::acq_status_t o_status,
	output logic                   o_wr_en,
	output scope_pkg::ram_addr_t   o_wr_addr,
	output scope_pkg::sample_t     o_wr_data
);

	scope_pkg::acq_state_e state;
	scope_pkg::ram_addr_t  wr_ptr;      // next write slot
	scope_pkg::byte_t      tot_cnt;     // samples past the second level
	logic                  none_armed;  // immediate trigger pending
	logic                  below;
	logic                  above;
	logic                  tot_hit;
	logic                  post_end;

	assign below   = (i_sample < i_cfg.lower);   // signed compare
	assign above   = (i_sample > i_cfg.upper);
	assign tot_hit = (state == scope_pkg::ACQ_FALL_TOT) ? above : below;

	// length 0 ends at once, otherwise on the last post sample
	assign post_end = (o_status.post_count >= i_cfg.length_to_take) ||
		(i_sample_valid && (o_status.post_count + 16'd1 >= i_cfg.length_to_take));

	// ---------------------------------------------------
	// buffer write side
	assign o_wr_en   = i_sample_valid && (state != scope_pkg::ACQ_DONE);  // freeze held event
	assign o_wr_addr = wr_ptr;
	assign o_wr_data = i_sample;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
		end else if (o_wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;  // wraps at 1024
		end
	end

	// ---------------------------------------------------
	// trigger FSM
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= scope_pkg::ACQ_IDLE;
			tot_cnt    <= '0;
			none_armed <= 1'b0;
			o_status   <= '0;
		end else begin
			case (state)
				scope_pkg::ACQ_IDLE: begin
					o_status.post_count <= '0;
					tot_cnt             <= '0;
					if (none_armed) begin
						if (i_sample_valid) begin  // this sample is the trigger
							none_armed         <= 1'b0;
							o_status.trig_addr <= wr_ptr;
							state              <= scope_pkg::ACQ_POST;
						end
					end else if (i_arm) begin
						case (i_cfg.trig_type)
							scope_pkg::TRIG_FALL: state <= scope_pkg::ACQ_FALL_ARM;
							scope_pkg::TRIG_RISE: state <= scope_pkg::ACQ_RISE_ARM;
							default:              none_armed <= 1'b1;  // next sample
						endcase
					end
				end

				scope_pkg::ACQ_FALL_ARM: begin
					if (i_sample_valid && below) state <= scope_pkg::ACQ_FALL_TOT;
				end

				scope_pkg::ACQ_RISE_ARM: begin
					if (i_sample_valid && above) state <= scope_pkg::ACQ_RISE_TOT;
				end

				scope_pkg::ACQ_FALL_TOT, scope_pkg::ACQ_RISE_TOT: begin
					if (i_sample_valid && tot_hit) begin
						tot_cnt <= tot_cnt + 8'd1;
						if (tot_cnt >= i_cfg.tot) begin  // count already there
							o_status.trig_addr <= wr_ptr;
							state              <= scope_pkg::ACQ_POST;
						end
					end
				end

				scope_pkg::ACQ_POST: begin
					if (post_end) begin
						o_status.event_count <= o_status.event_count + 16'd1;
						o_status.post_count  <= '1;  // event ready marker
						state                <= scope_pkg::ACQ_DONE;
					end else if (i_sample_valid) begin
						o_status.post_count <= o_status.post_count + 16'd1;
					end
				end

				scope_pkg::ACQ_DONE: begin
					if (i_readout_done) state <= scope_pkg::ACQ_IDLE;
				end

				default: state <= scope_pkg::ACQ_IDLE;
			endcase
		end
	end

	// held event keeps its buffer slots untouched
	a_no_write_done: assert property (@(posedge clk) disable iff (!rstn)
		(state == scope_pkg::ACQ_DONE) |=> $stable(wr_ptr));

endmodule

// File: design/cmd_rx.sv
/* command receiver
   collects host bytes into one 8-byte frame, opcode first,
   and strobes the frame once it is complete */

`include "scope_defines.svh"

module cmd_rx (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  i_rx_valid,
	input  scope_pkg::byte_t      i_rx_data,
	output logic                  o_rx_ready,
	input  logic                  i_listen,
	output scope_pkg::cmd_frame_t o_frame,
	output logic                  o_frame_valid
);

	localparam int CNT_W   = $clog2(`CMD_BYTES);
	localparam int FRAME_W = 8 * `CMD_BYTES;

	logic [CNT_W-1:0] byte_cnt;   // bytes in so far
	logic             rx_take;    // handshake this cycle
	logic             last_byte;

	assign o_rx_ready = i_listen && !o_frame_valid;  // hold off while frame is out
	assign rx_take    = i_rx_valid && o_rx_ready;
	assign last_byte  = (byte_cnt == CNT_W'(`CMD_BYTES - 1));

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt      <= '0;
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= rx_take && last_byte;  // one cycle after byte 8
			if (rx_take) begin
				byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
			end
		end
	end

	// first byte shifts up to the opcode slot
	always_ff @(posedge clk) begin
		if (rx_take) begin
			o_frame <= scope_pkg::cmd_frame_t'({o_frame[FRAME_W-9:0], i_rx_data});
		end
	end

	a_frame_when_listening: assert property (@(posedge clk) disable iff (!rstn)
		o_frame_valid |-> i_listen);

endmodule

// File: design/scope_pkg.sv
/* scope types
   vectors, command frame, acquisition config/status and FSM states */

`include "scope_defines.svh"

package scope_pkg;

	typedef logic signed [`SAMPLE_W-1:0] sample_t;  // two's complement adc code
	typedef logic [`RAM_AW-1:0]          ram_addr_t;
	typedef logic [15:0]                 count16_t;
	typedef logic [7:0]                  byte_t;

	typedef enum logic [7:0] {
		OP_READOUT  = 8'd0,   // stream the held event
		OP_ARM      = 8'd1,   // arm + status
		OP_INFO     = 8'd2,   // version
		OP_TRIG_SET = 8'd8    // levels, preoffset, tot
	} opcode_e;

	typedef enum logic [7:0] {
		TRIG_NONE = 8'd0,
		TRIG_FALL = 8'd1,
		TRIG_RISE = 8'd2
	} trig_type_e;

	// ---------------------------------------------------
	// opcode lands in the top byte
	typedef struct packed {
		byte_t opcode;
		byte_t arg1;
		byte_t arg2;
		byte_t arg3;
		byte_t arg4;
		byte_t arg5;
		byte_t arg6;
		byte_t arg7;
	} cmd_frame_t;

	typedef struct packed {
		trig_type_e trig_type;
		sample_t    lower;          // threshold low
		sample_t    upper;          // threshold high
		byte_t      tot;            // samples past 2nd level before trigger
		count16_t   length_to_take; // post-trigger samples
	} acq_cfg_t;

	typedef struct packed {
		count16_t  event_count;
		count16_t  post_count;     // all ones while an event is held
		ram_addr_t trig_addr;
	} acq_status_t;

	typedef enum logic [2:0] {
		ACQ_IDLE, ACQ_FALL_ARM, ACQ_FALL_TOT, ACQ_RISE_ARM, ACQ_RISE_TOT, ACQ_POST, ACQ_DONE
	} acq_state_e;

	typedef enum logic [2:0] {
		EX_RX, EX_PROCESS, EX_TX_CONST, EX_RD_LO, EX_RD_HI, EX_TX_DATA
	} exec_state_e;

endpackage

// File: design/scope_defines.svh
/* scope constants
   widths, buffer size, version number and threshold scaling
   shared by the package, the RTL and the testbench */

`ifndef SCOPE_DEFINES_SVH
`define SCOPE_DEFINES_SVH

`define SCOPE_VERSION 17    // answered by the info command

`define SAMPLE_W      12    // adc sample bits
`define RAM_AW        10    // 1024 entry ring buffer
`define CMD_BYTES     8     // host frame length

// ---------------------------------------------------
// level byte to 12-bit threshold
`define THRESH_MID    128   // mid code of the level byte
`define THRESH_SHIFT  4     // 8-bit level up to 12 bits
`define THRESH_ROUND  8     // half lsb after the shift

`endif
